// File: fwdPkg.sv
// Forwarding stage package with operand widths, unit count, select codes and bus types
package fwdPkg;

  localparam int DataWidth = 64;
  localparam int HalfWidth = 32;  // kept bits for 32-bit operations
  localparam int NumUnits = 10;
  localparam int SelWidth = 4;
  localparam int UnitIdxWidth = $clog2(NumUnits);

  localparam int LastUnit = NumUnits - 1;  // codes past the last unit fold onto it

  localparam logic [SelWidth-1:0] SelNone = 4'd15;

  // lower half kept, upper half cleared on a narrow request
  localparam logic [DataWidth-1:0] NarrowMask = {
    {(DataWidth - HalfWidth){1'b0}},
    {HalfWidth{1'b1}}
  };

  typedef logic [DataWidth-1:0] dataWord_t;

  typedef logic [SelWidth-1:0] unitSel_t;

  typedef logic [UnitIdxWidth-1:0] unitIdx_t;

  // one word per functional unit, unit 0 in the low word
  typedef struct packed {
    dataWord_t [NumUnits-1:0] fu;
  } resultBus_t;

  // decoded source select
  typedef struct packed {
    logic     hit;  // select names a unit
    unitIdx_t idx;
  } selDecode_t;

  typedef struct packed {
    dataWord_t oldData;   // value already held in the station
    unitSel_t  earlySel;  // unit on the current result bus
    unitSel_t  lateSel;   // unit on the bus of the previous cycle
    logic      narrow;    // clear the upper half of the result
    logic      auxEn;     // auxData replaces the late path
    dataWord_t auxData;   // return address of an indirect jump
  } fwdReq_t;

endpackage

// File: resultBusDelay.sv
// Result bus delay register that forms the late bus from the previous cycle's results
module resultBusDelay (
  input  logic               clk,
  input  logic               rst,
  input  fwdPkg::resultBus_t resultBus,
  output fwdPkg::resultBus_t lateBus
);

  // The register is never stalled. Each unit's result is offered on the late
  // bus for exactly one cycle after it appears on the result bus, which is why
  // the operand stage has to capture the operand at acceptance.

  fwdPkg::resultBus_t busReg;

  always_ff @(posedge clk) begin
    if (rst) begin
      busReg <= '0;
    end else begin
      busReg <= resultBus;  // loaded on every edge
    end
  end

  assign lateBus = busReg;

endmodule

// File: operandBypassMux.sv
// Operand bypass mux choosing early, auxiliary, late or stored data with a narrow clear
module operandBypassMux (
  input  fwdPkg::fwdReq_t    req,
  input  fwdPkg::resultBus_t resultBus,
  input  fwdPkg::resultBus_t lateBus,
  output fwdPkg::dataWord_t  fwdData
);

  import fwdPkg::*;

  // Codes 0 to 9 name a unit directly. Codes 10 to 14 are decoded as unit 9,
  // matching the older select encoding, and SelNone names no unit at all.
  function automatic selDecode_t decodeSel(input unitSel_t sel);
    selDecode_t dec;
    dec.hit = (sel != SelNone);
    if (sel > unitSel_t'(LastUnit)) begin
      dec.idx = unitIdx_t'(LastUnit);
    end else begin
      dec.idx = unitIdx_t'(sel);
    end
    return dec;
  endfunction

  selDecode_t earlyDec;
  selDecode_t lateDec;

  dataWord_t earlyWord;
  dataWord_t lateWord;
  dataWord_t chosenWord;

  assign earlyDec = decodeSel(req.earlySel);
  assign lateDec  = decodeSel(req.lateSel);

  assign earlyWord = resultBus.fu[earlyDec.idx];  // result produced this cycle
  assign lateWord  = lateBus.fu[lateDec.idx];      // result from one cycle back

  // fixed priority replaces the old tristate resolution
  always_comb begin
    if (earlyDec.hit) begin
      chosenWord = earlyWord;
    end else if (req.auxEn) begin
      chosenWord = req.auxData;  // jalr return address wins over the late path
    end else if (lateDec.hit) begin
      chosenWord = lateWord;
    end else begin
      chosenWord = req.oldData;
    end
  end

  // the narrow clear applies after selection, on every path
  always_comb begin
    if (req.narrow) begin
      fwdData = chosenWord & NarrowMask;
    end else begin
      fwdData = chosenWord;
    end
  end

endmodule

// File: operandStage.sv
// Operand output register with a valid/ready handshake on both sides
module operandStage (
  input  logic              clk,
  input  logic              rst,
  input  logic              inValid,
  input  logic              outReady,
  input  fwdPkg::dataWord_t fwdData,
  output logic              inReady,
  output logic              outValid,
  output fwdPkg::dataWord_t outData
);

  logic loadEn;   // request accepted on this edge
  logic leaveEn;  // held result taken downstream on this edge

  // free when empty, or when the held result leaves on this same edge
  assign inReady = ~outValid | outReady;

  assign loadEn  = inValid & inReady;
  assign leaveEn = outValid & outReady;

  always_ff @(posedge clk) begin
    if (rst) begin
      outValid <= 1'b0;
    end else if (loadEn) begin
      outValid <= 1'b1;  // covers the replace-on-leave case too
    end else if (leaveEn) begin
      outValid <= 1'b0;
    end
  end

  // The operand is frozen here at acceptance. The late bus keeps moving, so
  // back-pressure must not let the mux output reach this register again.
  always_ff @(posedge clk) begin
    if (rst) begin
      outData <= '0;
    end else if (loadEn) begin
      outData <= fwdData;
    end
  end

endmodule

// File: rsWriteForward.sv
// Reservation station operand write-forwarding stage with early, late and auxiliary sources
module rsWriteForward (
  input  logic               clk,
  input  logic               rst,
  input  fwdPkg::resultBus_t resultBus,
  input  fwdPkg::fwdReq_t    req,
  input  logic               inValid,
  input  logic               outReady,
  output logic               inReady,
  output logic               outValid,
  output fwdPkg::dataWord_t  outData
);

  import fwdPkg::*;

  resultBus_t lateBus;  // result bus of the previous cycle
  dataWord_t  fwdData;  // forwarded operand, valid while req is held

  // late bus source, kept inside the block
  resultBusDelay i_resultBusDelay (
    .clk       (clk),
    .rst       (rst),
    .resultBus (resultBus),
    .lateBus   (lateBus)
  );

  // combinational selection in the cycle of acceptance
  operandBypassMux i_operandBypassMux (
    .req       (req),
    .resultBus (resultBus),
    .lateBus   (lateBus),
    .fwdData   (fwdData)
  );

  // one register of latency, at most one operand in flight
  operandStage i_operandStage (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .outReady (outReady),
    .fwdData  (fwdData),
    .inReady  (inReady),
    .outValid (outValid),
    .outData  (outData)
  );

endmodule

// File: rsWriteForward_props.sv
// Handshake and reset assertions bound to the forwarding stage top level
module rsWriteForwardProps (
  input logic              clk,
  input logic              rst,
  input logic              outReady,
  input logic              inReady,
  input logic              outValid,
  input fwdPkg::dataWord_t outData
);

  timeunit 1ns;
  timeprecision 1ps;

  // the output register is empty and cleared once reset has been seen
  resetClearsOutput: assert property (@(posedge clk) rst |=> (!outValid && outData == '0))
    else $error("output register not cleared after reset");

  // a stalled result must not change or vanish
  holdWhileStalled: assert property (@(posedge clk) disable iff (rst)
    (outValid && !outReady) |=> (outValid && $stable(outData)))
    else $error("held result changed while outReady was low");

  readyRule: assert property (@(posedge clk) disable iff (rst)
    inReady == (!outValid || outReady))
    else $error("inReady does not follow outValid and outReady");

endmodule

bind rsWriteForward rsWriteForwardProps i_rsWriteForwardProps (
  .clk      (clk),
  .rst      (rst),
  .outReady (outReady),
  .inReady  (inReady),
  .outValid (outValid),
  .outData  (outData)
);

// File: rsWriteForward_tb.sv
// Testbench for the forwarding stage with random bus traffic, a reference model and ordered checks
module rsWriteForward_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import fwdPkg::*;

  localparam int ClkPeriod = 8;
  localparam int ResetCycles = 2;
  localparam int NumDirected = 37;  // early, late, priority and narrow cases
  localparam int NumRandom = 300;
  localparam int NumReqs = NumDirected + NumRandom;
  localparam int CyclesPerReq = 20;

  logic       clk;
  logic       rst;
  resultBus_t resultBus;
  fwdReq_t    req;
  logic       inValid;
  logic       outReady;
  logic       inReady;
  logic       outValid;
  dataWord_t  outData;

  fwdReq_t     reqList [NumReqs];
  dataWord_t   expQ [$];      // expected operands in acceptance order
  resultBus_t  lateModel;     // bus seen on the previous edge
  logic [31:0] rngState = 32'h68898bbc;
  int          doneCount = 0;

  rsWriteForward i_rsWriteForward (
    .clk       (clk),
    .rst       (rst),
    .resultBus (resultBus),
    .req       (req),
    .inValid   (inValid),
    .outReady  (outReady),
    .inReady   (inReady),
    .outValid  (outValid),
    .outData   (outData)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  function automatic logic [31:0] nextRand();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  function automatic logic randBit();
    logic [31:0] r;
    r = nextRand();
    return r[16];
  endfunction

  function automatic dataWord_t randWord();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = nextRand();
    lo = nextRand();
    return {hi, lo};
  endfunction

  // about half of the random selects name no unit at all
  function automatic unitSel_t randSel();
    logic [31:0] r;
    r = nextRand();
    if (r[31]) begin
      return SelNone;
    end
    return r[3:0];
  endfunction

  function automatic resultBus_t randBus();
    resultBus_t bus;
    for (int u = 0; u < NumUnits; u++) begin
      bus.fu[u] = randWord();
    end
    return bus;
  endfunction

  function automatic fwdReq_t makeReq(input unitSel_t early, input unitSel_t late,
                                      input logic aux, input logic narrow);
    fwdReq_t r;
    r.oldData  = randWord();
    r.earlySel = early;
    r.lateSel  = late;
    r.narrow   = narrow;
    r.auxEn    = aux;
    r.auxData  = randWord();
    return r;
  endfunction

  // codes past the last unit are an alias for unit 9
  function automatic int unitOf(input unitSel_t sel);
    if (int'(sel) >= NumUnits) begin
      return NumUnits - 1;
    end
    return int'(sel);
  endfunction

  function automatic dataWord_t expectedOperand(input fwdReq_t r, input resultBus_t bus,
                                                input resultBus_t late);
    dataWord_t word;
    if (r.earlySel != SelNone) begin
      word = bus.fu[unitOf(r.earlySel)];
    end else if (r.auxEn) begin
      word = r.auxData;
    end else if (r.lateSel != SelNone) begin
      word = late.fu[unitOf(r.lateSel)];
    end else begin
      word = r.oldData;
    end
    if (r.narrow) begin
      word[DataWidth-1:HalfWidth] = '0;  // 32-bit operation
    end
    return word;
  endfunction

  task automatic failRun(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic checkValue(input string name, input dataWord_t got, input dataWord_t exp);
    if (got !== exp) begin
      failRun($sformatf("FAILED: %s got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic buildRequests();
    int n;
    n = 0;
    for (int s = 0; s < 15; s++) begin
      reqList[n] = makeReq(unitSel_t'(s), randSel(), randBit(), 1'b0);  // every early code
      n++;
    end
    for (int s = 0; s < 15; s++) begin
      reqList[n] = makeReq(SelNone, unitSel_t'(s), 1'b0, 1'b0);
      n++;
    end
    reqList[n] = makeReq(4'd3, 4'd5, 1'b1, 1'b0);  // early over aux
    reqList[n + 1] = makeReq(SelNone, 4'd5, 1'b1, 1'b0);  // aux over late
    reqList[n + 2] = makeReq(SelNone, SelNone, 1'b0, 1'b0);
    n = n + 3;
    // narrow clear on each of the four paths
    reqList[n] = makeReq(4'd7, SelNone, 1'b0, 1'b1);
    reqList[n + 1] = makeReq(SelNone, SelNone, 1'b1, 1'b1);
    reqList[n + 2] = makeReq(SelNone, 4'd2, 1'b0, 1'b1);
    reqList[n + 3] = makeReq(SelNone, SelNone, 1'b0, 1'b1);
    n = n + 4;
    for (int i = 0; i < NumRandom; i++) begin
      reqList[n] = makeReq(randSel(), randSel(), randBit() & randBit(), randBit());
      n++;
    end
  endtask

  initial begin : driveStimulus
    int idx;
    idx       = 0;
    rst       = 1'b1;
    inValid   = 1'b0;
    outReady  = 1'b0;
    req       = '0;
    resultBus = '0;
    buildRequests();
    repeat (ResetCycles) @(posedge clk);
    rst <= 1'b0;
    forever begin
      @(posedge clk);
      if (inValid && inReady) begin
        idx++;
      end
      resultBus <= randBus();
      outReady  <= randBit();
      // a pending request is held until it transfers
      if (!(inValid && !inReady)) begin
        if (idx < NumReqs && randBit()) begin
          req     <= reqList[idx];
          inValid <= 1'b1;
        end else begin
          inValid <= 1'b0;
        end
      end
    end
  end

  always @(posedge clk) begin : trackRequests
    if (!rst && inValid && inReady) begin
      expQ.push_back(expectedOperand(req, resultBus, lateModel));
    end
    if (rst) begin
      lateModel <= '0;
    end else begin
      lateModel <= resultBus;
    end
  end

  always @(posedge clk) begin : compareResults
    dataWord_t expWord;
    if (!rst && outValid && outReady) begin
      if (expQ.size() == 0) begin
        failRun("a result left the stage with no request outstanding");
      end else begin
        expWord = expQ.pop_front();
        checkValue("outData", outData, expWord);
        doneCount++;
      end
    end
  end

  initial begin : watchdog
    repeat (ResetCycles + NumReqs * CyclesPerReq) @(posedge clk);
    failRun("timeout while waiting for the remaining results");
  end

  initial begin : finishRun
    repeat (ResetCycles + 1) @(posedge clk);
    checkValue("outValid", dataWord_t'(outValid), '0);  // idle straight after reset
    checkValue("inReady", dataWord_t'(inReady), dataWord_t'(1'b1));
    while (doneCount < NumReqs) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    if (!outValid) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      failRun("the stage still held a result after the last expected one had left");
    end
  end

endmodule

// File: rsWriteForward.f
fwdPkg.sv
resultBusDelay.sv
operandBypassMux.sv
operandStage.sv
rsWriteForward.sv
rsWriteForward_props.sv
rsWriteForward_tb.sv

// File: Makefile
# Verilator build and run of the rsWriteForward testbench

.PHONY: all compile run clean

all: run

compile: obj_dir/VrsWriteForward_tb

obj_dir/VrsWriteForward_tb: rsWriteForward.f $(wildcard *.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module rsWriteForward_tb -Mdir obj_dir -f rsWriteForward.f

# the exit status of the simulation is the test result
run: compile
	./obj_dir/VrsWriteForward_tb

clean:
	rm -rf obj_dir
